/* dv/fp_ref_model.svh */
/*
 * fp issue stage reference model
 * expected value of each sign and compare operation, and the completion
 * order that sync entries impose; included into the testbench module
 * after its scoreboard arrays
 */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// places sign and magnitude on one signed scale where -0 sits just below +0
function automatic logic signed [32:0] key_of(input logic [31:0] x);
	logic signed [32:0] mag;
	mag = $signed({2'b00, x[30:0]});
	if (x[31]) begin
		return -mag - 33'sd1;
	end
	return mag;
endfunction

// equal keys mean equal bit patterns, so either operand is right on a tie
function automatic logic [31:0] expected_value(input fpq_pkg::fp_entry_t e);
	case (e.op)
		fpq_pkg::OP_MIN: return (key_of(e.b) < key_of(e.a)) ? e.b : e.a;
		fpq_pkg::OP_MAX: return (key_of(e.b) > key_of(e.a)) ? e.b : e.a;
		fpq_pkg::OP_NEG: return e.a ^ 32'h8000_0000;
		default: return e.a & 32'h7fff_ffff;
	endcase
endfunction

// nothing may finish ahead of an older sync entry that is still pending,
// and a sync entry may not finish while anything older is pending
function automatic bit order_is_legal(input int tag);
	for (int i = 0; i < NTAGS; i++) begin
		if (pending[i] && i != tag && seq_of[i] < seq_of[tag]
				&& (is_sync[i] || is_sync[tag])) begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

`endif

/* dv/fp_issue_tb.sv */
/*
 * fp issue stage testbench
 * sends dispatch, wakeup and configuration traffic into the issue stage,
 * scores each lane result by tag against the reference model and checks
 * sync ordering, lane steering, issue hold and dispatch credit return
 */
module fp_issue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IQ_ENTRIES = 8;
	localparam int LANE_DEPTH = 2;
	localparam int NTAGS = 1 << fpq_pkg::TAG_W;
	localparam int WAIT_LIMIT = 2000;
	localparam logic [fpq_pkg::TAG_W-1:0] WAKE_SRC = 6'd50;

	logic                      clk = 1'b0;
	logic                      rst_n;
	logic                      disp_valid;
	fpq_pkg::fp_entry_t        disp_entry;
	logic                      disp_credit;
	logic                      wake_valid;
	logic [fpq_pkg::TAG_W-1:0] wake_tag;
	logic                      cfg_we;
	logic [1:0]                cfg_addr;
	logic [31:0]               cfg_wdata;
	logic [31:0]               cfg_rdata;
	fpq_pkg::fp_result_t       result0;
	fpq_pkg::fp_result_t       result1;

	// scoreboard, one slot per tag
	bit          pending [NTAGS];
	bit          is_sync [NTAGS];
	int          seq_of [NTAGS];
	logic [31:0] exp_val [NTAGS];

	int                        credits;
	int                        outstanding;
	int                        next_seq;
	logic [fpq_pkg::TAG_W-1:0] next_tag;
	int                        err_cnt;
	int                        test_err;
	int                        tests_run;
	int                        tests_failed;
	int                        checks;
	// lane1_off flags lane 1 traffic, quiet flags any result at all
	bit                        lane1_off;
	bit                        quiet;
	string                     cur_test;
	logic [31:0]               lcg_state;

	`include "fp_ref_model.svh"

	fp_issue_top #(.IQ_ENTRIES(IQ_ENTRIES), .LANE_DEPTH(LANE_DEPTH)) UUT (
		.clk(clk), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp_entry(disp_entry), .disp_credit(disp_credit),
		.wake_valid(wake_valid), .wake_tag(wake_tag),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.result0(result0), .result1(result1)
	);

	always #50 clk = ~clk;

	// ========================================
	// helpers
	// ========================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic finish_run();
		$display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
			tests_run, tests_failed, checks, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	task automatic abort_run(input string msg);
		$display("%s: %s", cur_test, msg);
		err_cnt++;
		finish_run();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err = err_cnt;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_cnt == test_err) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, err_cnt - test_err);
		end
	endtask

	// waits for a free queue slot, then drives one entry for a cycle
	task automatic send_op(input fpq_pkg::fp_entry_t e);
		int t;
		t = 0;
		@(posedge clk);
		while (credits == 0 && t < WAIT_LIMIT) begin
			disp_valid <= 1'b0;
			@(posedge clk);
			t++;
		end
		if (credits == 0) begin
			abort_run("no dispatch credit came back");
		end else begin
			disp_valid <= 1'b1;
			disp_entry <= e;
			credits--;
			pending[e.tag] = 1'b1;
			is_sync[e.tag] = e.sync;
			seq_of[e.tag] = next_seq;
			exp_val[e.tag] = expected_value(e);
			next_seq++;
			outstanding++;
		end
	endtask

	task automatic stop_dispatch();
		@(posedge clk);
		disp_valid <= 1'b0;
	endtask

	// n random ops, the one at sync_pos marked sync (-1 for none)
	task automatic send_random(input int n, input bit ready, input int sync_pos);
		fpq_pkg::fp_entry_t e;
		logic [31:0]        r;
		for (int i = 0; i < n; i++) begin
			r = lcg_next();
			e.op = fpq_pkg::fp_op_e'(r[30:29]);
			e.tag = next_tag;
			e.src_tag = WAKE_SRC;
			e.src_ready = ready;
			e.sync = (i == sync_pos);
			e.a = lcg_next();
			e.b = lcg_next();
			// every fifth op compares a value with its own negation
			if (i % 5 == 4) begin
				e.b = {~e.a[31], e.a[30:0]};
			end
			next_tag++;
			send_op(e);
		end
		stop_dispatch();
	endtask

	// one-cycle wakeup broadcast for a source tag
	task automatic send_wakeup(input logic [fpq_pkg::TAG_W-1:0] tag);
		@(posedge clk);
		wake_valid <= 1'b1;
		wake_tag <= tag;
		@(posedge clk);
		wake_valid <= 1'b0;
	endtask

	task automatic write_cfg(input logic [31:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= fpq_pkg::CFG_ADDR_CTRL;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	// read data is registered, so it is taken a full cycle after the address
	task automatic check_readback(input logic [31:0] expected);
		logic [31:0] data;
		@(posedge clk);
		cfg_addr <= fpq_pkg::CFG_ADDR_CTRL;
		@(posedge clk);
		@(negedge clk);
		data = cfg_rdata;
		assert (data == expected) else begin
			$display("error %s readback: expected %h actual %h", cur_test, expected, data);
			err_cnt++;
		end
	endtask

	// drained means no result owed and every dispatch credit back home
	task automatic wait_idle();
		int t;
		t = 0;
		while ((outstanding != 0 || credits != IQ_ENTRIES) && t < WAIT_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (outstanding != 0 || credits != IQ_ENTRIES) begin
			abort_run($sformatf("timed out with %0d results missing and %0d credits held",
				outstanding, credits));
		end
	endtask

	// ========================================
	// result compare
	// ========================================

	task automatic check_result(input fpq_pkg::fp_result_t r, input int lane);
		checks++;
		assert (pending[r.tag]) else begin
			$display("%s: tag %0d on lane %0d was never sent or came back twice",
				cur_test, r.tag, lane);
			err_cnt++;
		end
		if (pending[r.tag]) begin
			assert (r.value == exp_val[r.tag]) else begin
				$display("error %s: tag %0d expected %h actual %h",
					cur_test, r.tag, exp_val[r.tag], r.value);
				err_cnt++;
			end
			assert (order_is_legal(r.tag)) else begin
				$display("%s: tag %0d finished out of sync order", cur_test, r.tag);
				err_cnt++;
			end
			pending[r.tag] = 1'b0;
			outstanding--;
		end
		assert (!(lane == 1 && lane1_off)) else begin
			$display("%s: tag %0d came out of lane 1 while it was disabled", cur_test, r.tag);
			err_cnt++;
		end
		assert (!quiet) else begin
			$display("%s: tag %0d completed while no result was allowed", cur_test, r.tag);
			err_cnt++;
		end
	endtask

	// outputs settle after the rising edge, so they are looked at on the falling one
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (result0.valid) begin
				check_result(result0, 0);
			end
			if (result1.valid) begin
				check_result(result1, 1);
			end
			if (disp_credit) begin
				credits++;
			end
		end
	end

	// ========================================
	// test sequence
	// ========================================

	initial begin
		fpq_pkg::fp_entry_t e;
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp_entry = '0;
		wake_valid = 1'b0;
		wake_tag = '0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		lcg_state = 32'd8;
		credits = IQ_ENTRIES;
		next_tag = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		begin_test("op_results");
		send_random(24, 1'b1, -1);
		// signed zeros, where -0 must order below +0
		e = '0;
		e.op = fpq_pkg::OP_MIN;
		e.tag = next_tag;
		e.src_ready = 1'b1;
		e.b = 32'h8000_0000;
		next_tag++;
		send_op(e);
		e.op = fpq_pkg::OP_MAX;
		e.tag = next_tag;
		next_tag++;
		send_op(e);
		stop_dispatch();
		wait_idle();
		end_test();

		begin_test("wakeup_gating");
		quiet = 1'b1;
		send_random(4, 1'b0, -1);
		repeat (20) @(posedge clk);
		quiet = 1'b0;
		send_wakeup(WAKE_SRC);
		wait_idle();
		end_test();

		// one sync in the middle of a batch, one at the head of the next
		begin_test("sync_ordering");
		send_random(8, 1'b1, 3);
		send_random(6, 1'b1, 0);
		wait_idle();
		// older ops wait on their source while a ready sync and ready younger ops queue up
		send_random(3, 1'b0, -1);
		send_random(5, 1'b1, 0);
		repeat (10) @(posedge clk);
		send_wakeup(WAKE_SRC);
		wait_idle();
		end_test();

		begin_test("lane_config");
		write_cfg(32'h1);
		lane1_off = 1'b1;
		check_readback(32'h1);
		send_random(10, 1'b1, -1);
		wait_idle();
		lane1_off = 1'b0;
		write_cfg(32'h7);
		check_readback(32'h7);
		quiet = 1'b1;
		send_random(6, 1'b1, -1);
		repeat (50) @(posedge clk);
		quiet = 1'b0;
		write_cfg(32'h3);
		check_readback(32'h3);
		wait_idle();
		end_test();

		// the hold lets the queue fill so the sender runs dry of credits
		begin_test("credit_flow");
		write_cfg(32'h7);
		send_random(IQ_ENTRIES, 1'b1, -1);
		assert (credits == 0) else begin
			$display("%s: %0d credits left with the queue full", cur_test, credits);
			err_cnt++;
		end
		write_cfg(32'h3);
		send_random(16, 1'b1, -1);
		wait_idle();
		end_test();

		finish_run();
	end

endmodule

/* rtl/fp_issue_cfg.sv */
/*
 * fp issue configuration registers
 * one control register with the two lane enables and the issue hold,
 * written over a simple bus and read back one cycle later
 */
module fp_issue_cfg (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cfg_we,
	input  logic [1:0]       cfg_addr,
	input  logic [31:0]      cfg_wdata,
	output logic [31:0]      cfg_rdata,
	output fpq_pkg::fp_cfg_t cfg
);

	logic ctrl_sel;

	assign ctrl_sel = (cfg_addr == fpq_pkg::CFG_ADDR_CTRL);

	// ========================================
	// control register and read port
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.lane_en <= fpq_pkg::CFG_LANE_EN_RST;
			cfg.issue_hold <= 1'b0;
			cfg_rdata <= '0;
		end else begin
			if (cfg_we && ctrl_sel) begin
				cfg.lane_en <= cfg_wdata[1:0];
				cfg.issue_hold <= cfg_wdata[2];
			end
			// unmapped addresses read as zero
			if (ctrl_sel) begin
				cfg_rdata <= {29'd0, cfg.issue_hold, cfg.lane_en};
			end else begin
				cfg_rdata <= '0;
			end
		end
	end

endmodule

/* rtl/fp_issue_queue.sv */
/*
 * fp collapsing issue queue
 * entries stay ordered by age with index 0 the oldest, picked entries are
 * removed at the edge and the survivors slide down, new dispatch lands
 * right after them; also builds the ready and sync-ordering masks and
 * returns one dispatch credit pulse per freed entry
 */
module fp_issue_queue #(
	parameter int IQ_ENTRIES = 8
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        disp_valid,
	input  fpq_pkg::fp_entry_t          disp_entry,
	output logic                        disp_credit,
	input  logic                        wake_valid,
	input  logic [fpq_pkg::TAG_W-1:0]   wake_tag,
	input  logic [IQ_ENTRIES-1:0]       pick0,
	input  logic [IQ_ENTRIES-1:0]       pick1,
	output logic [IQ_ENTRIES-1:0]       could_issue,
	output logic [IQ_ENTRIES-1:0]       prior_sync,
	output fpq_pkg::fp_entry_t          entries [IQ_ENTRIES]
);

	// one spare bit so pending plus removed never wraps
	localparam int CNT_W = $clog2(IQ_ENTRIES + 1) + 1;

	logic [IQ_ENTRIES-1:0] valid_q;
	logic [IQ_ENTRIES-1:0] valid_d;
	fpq_pkg::fp_entry_t    entries_d [IQ_ENTRIES];
	logic [CNT_W-1:0]      removed;
	logic [CNT_W-1:0]      credit_pend;
	logic [CNT_W-1:0]      credit_sum;
	logic                  credit_out;

	// ========================================
	// collapse, append and wakeup
	// ========================================

	always_comb begin
		int                 k;
		fpq_pkg::fp_entry_t ent;
		k = 0;
		valid_d = '0;
		removed = '0;
		// unused slots simply keep their old contents
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			entries_d[i] = entries[i];
		end
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			ent = entries[i];
			// a matching wakeup marks the source ready as the entry moves
			if (wake_valid && ent.src_tag == wake_tag) begin
				ent.src_ready = 1'b1;
			end
			if (valid_q[i] && (pick0[i] || pick1[i])) begin
				removed = removed + CNT_W'(1);
			end else if (valid_q[i]) begin
				// survivors are packed toward index 0 in age order
				entries_d[k] = ent;
				valid_d[k] = 1'b1;
				k = k + 1;
			end
		end
		// the new entry is the youngest so it goes right after the survivors
		if (disp_valid && k < IQ_ENTRIES) begin
			ent = disp_entry;
			// a wakeup in the dispatch cycle must not be lost
			if (wake_valid && ent.src_tag == wake_tag) begin
				ent.src_ready = 1'b1;
			end
			entries_d[k] = ent;
			valid_d[k] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_d;
		end
	end

	always_ff @(posedge clk) begin
		entries <= entries_d;
	end

	// ========================================
	// readiness and sync masks
	// ========================================

	// valid entries are contiguous from 0, so walking up the index
	// visits them from oldest to youngest
	always_comb begin
		logic older_valid;
		logic older_sync;
		older_valid = 1'b0;
		older_sync = 1'b0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			could_issue[i] = valid_q[i] && entries[i].src_ready;
			// blocked behind an older sync, or a sync that still has older work
			prior_sync[i] = valid_q[i] && (older_sync || (entries[i].sync && older_valid));
			older_valid = older_valid | valid_q[i];
			older_sync = older_sync | (valid_q[i] && entries[i].sync);
		end
	end

	// ========================================
	// dispatch credit return
	// ========================================

	// up to two entries leave per cycle but only one pulse goes out,
	// the rest wait in credit_pend
	assign credit_sum = credit_pend + removed;
	assign credit_out = (credit_sum != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_pend <= '0;
			disp_credit <= 1'b0;
		end else begin
			credit_pend <= credit_sum - CNT_W'(credit_out);
			disp_credit <= credit_out;
		end
	end

endmodule

/* rtl/fp_issue_select.sv */
/*
 * fp issue selector
 * picks the oldest eligible entry for lane 0 and the next oldest for
 * lane 1, gates each lane on credits, enable and hold, keeps the lane
 * credit counters and registers the two issue packets
 */
module fp_issue_select #(
	parameter int IQ_ENTRIES = 8,
	parameter int LANE_DEPTH = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [IQ_ENTRIES-1:0] could_issue,
	input  logic [IQ_ENTRIES-1:0] prior_sync,
	input  fpq_pkg::fp_entry_t    entries [IQ_ENTRIES],
	input  fpq_pkg::fp_cfg_t      cfg,
	input  logic [1:0]            lane_credit,
	output logic [IQ_ENTRIES-1:0] pick0,
	output logic [IQ_ENTRIES-1:0] pick1,
	output fpq_pkg::fp_issue_t    issue0,
	output fpq_pkg::fp_issue_t    issue1
);

	localparam int CRD_W = $clog2(LANE_DEPTH + 1);

	logic [CRD_W-1:0]   credit_q [2];
	logic [1:0]         lane_ok;
	logic [1:0]         issued;
	fpq_pkg::fp_entry_t pick0_entry;
	fpq_pkg::fp_entry_t pick1_entry;

	// a lane may take work only with a free buffer slot, enabled and not held
	always_comb begin
		for (int l = 0; l < 2; l++) begin
			lane_ok[l] = (credit_q[l] != '0) && cfg.lane_en[l] && !cfg.issue_hold;
		end
	end

	// ========================================
	// pick logic
	// ========================================

	// lowest index wins, which is the oldest entry in the collapsing queue
	always_comb begin
		pick0 = '0;
		pick1 = '0;
		pick0_entry = '0;
		pick1_entry = '0;
		if (lane_ok[0]) begin
			for (int n = 0; n < IQ_ENTRIES; n++) begin
				if (could_issue[n] && !prior_sync[n] && pick0 == '0) begin
					pick0[n] = 1'b1;
					pick0_entry = entries[n];
				end
			end
		end
		// lane 1 skips whatever lane 0 already took
		if (lane_ok[1]) begin
			for (int n = 0; n < IQ_ENTRIES; n++) begin
				if (could_issue[n] && !prior_sync[n] && !pick0[n] && pick1 == '0) begin
					pick1[n] = 1'b1;
					pick1_entry = entries[n];
				end
			end
		end
	end

	assign issued = {|pick1, |pick0};

	// issue packets and credits move on the same edge the queue drops the entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue0 <= '0;
			issue1 <= '0;
			credit_q[0] <= CRD_W'(LANE_DEPTH);
			credit_q[1] <= CRD_W'(LANE_DEPTH);
		end else begin
			issue0 <= '{valid: issued[0], entry: pick0_entry};
			issue1 <= '{valid: issued[1], entry: pick1_entry};
			for (int l = 0; l < 2; l++) begin
				credit_q[l] <= credit_q[l] - CRD_W'(issued[l]) + CRD_W'(lane_credit[l]);
			end
		end
	end

endmodule

/* rtl/fp_issue_top.sv */
/*
 * fp issue stage top level
 * collapsing issue queue, configuration registers, two-wide selector and
 * two sign and compare lanes, each returning its own result stream
 */
module fp_issue_top #(
	parameter int IQ_ENTRIES = 8,
	parameter int LANE_DEPTH = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      disp_valid,
	input  fpq_pkg::fp_entry_t        disp_entry,
	output logic                      disp_credit,
	input  logic                      wake_valid,
	input  logic [fpq_pkg::TAG_W-1:0] wake_tag,
	input  logic                      cfg_we,
	input  logic [1:0]                cfg_addr,
	input  logic [31:0]               cfg_wdata,
	output logic [31:0]               cfg_rdata,
	output fpq_pkg::fp_result_t       result0,
	output fpq_pkg::fp_result_t       result1
);

	// queue to selector
	logic [IQ_ENTRIES-1:0] could_issue;
	logic [IQ_ENTRIES-1:0] prior_sync;
	fpq_pkg::fp_entry_t    entries [IQ_ENTRIES];
	// selector to queue
	logic [IQ_ENTRIES-1:0] pick0;
	logic [IQ_ENTRIES-1:0] pick1;
	// selector, lanes and config
	fpq_pkg::fp_cfg_t      cfg;
	fpq_pkg::fp_issue_t    issue0;
	fpq_pkg::fp_issue_t    issue1;
	logic [1:0]            lane_credit;

	fp_issue_queue #(.IQ_ENTRIES(IQ_ENTRIES)) u_queue (
		.clk(clk), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp_entry(disp_entry), .disp_credit(disp_credit),
		.wake_valid(wake_valid), .wake_tag(wake_tag),
		.pick0(pick0), .pick1(pick1),
		.could_issue(could_issue), .prior_sync(prior_sync), .entries(entries)
	);

	fp_issue_cfg u_cfg (
		.clk(clk), .rst_n(rst_n),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata), .cfg(cfg)
	);

	fp_issue_select #(.IQ_ENTRIES(IQ_ENTRIES), .LANE_DEPTH(LANE_DEPTH)) u_select (
		.clk(clk), .rst_n(rst_n),
		.could_issue(could_issue), .prior_sync(prior_sync), .entries(entries),
		.cfg(cfg), .lane_credit(lane_credit),
		.pick0(pick0), .pick1(pick1), .issue0(issue0), .issue1(issue1)
	);

	fp_lane #(.LANE_DEPTH(LANE_DEPTH)) u_lane0 (
		.clk(clk), .rst_n(rst_n),
		.issue(issue0), .lane_credit(lane_credit[0]), .result(result0)
	);

	fp_lane #(.LANE_DEPTH(LANE_DEPTH)) u_lane1 (
		.clk(clk), .rst_n(rst_n),
		.issue(issue1), .lane_credit(lane_credit[1]), .result(result1)
	);

endmodule

/* rtl/fp_lane.sv */
/*
 * fp execution lane
 * a small FIFO sized to the selector's credits feeds a two-stage pipe,
 * stage 1 compares sign and magnitude and stage 2 picks min, max,
 * negated or absolute value; one credit goes back per item popped
 */
module fp_lane #(
	parameter int LANE_DEPTH = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  fpq_pkg::fp_issue_t  issue,
	output logic                lane_credit,
	output fpq_pkg::fp_result_t result
);

	localparam int PTR_W = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
	localparam int CNT_W = $clog2(LANE_DEPTH + 1);

	fpq_pkg::fp_entry_t buf_mem [LANE_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               push;
	logic               pop;

	logic               s1_valid;
	fpq_pkg::fp_entry_t s1_entry;
	logic               s1_a_lt_b;
	logic               s2_valid;
	fpq_pkg::fp_entry_t s2_entry;
	logic               s2_a_lt_b;
	logic [31:0]        s2_value;

	// ========================================
	// input buffer
	// ========================================

	// credits guarantee a free slot whenever issue.valid is set
	assign push = issue.valid;
	assign pop = (count != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lane_credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
			// slot is free again once its item is in the pipe
			lane_credit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			buf_mem[wr_ptr] <= issue.entry;
		end
	end

	// ========================================
	// stage 1, sign and magnitude compare
	// ========================================

	always_comb begin
		logic        sa;
		logic        sb;
		logic [30:0] ma;
		logic [30:0] mb;
		sa = s1_entry.a[31];
		sb = s1_entry.b[31];
		ma = s1_entry.a[30:0];
		mb = s1_entry.b[30:0];
		// different signs, the negative one is smaller (so -0 < +0)
		if (sa != sb) begin
			s1_a_lt_b = sa;
		end else if (sa) begin
			s1_a_lt_b = (ma > mb);
		end else begin
			s1_a_lt_b = (ma < mb);
		end
	end

	// ========================================
	// stage 2, result select
	// ========================================

	always_comb begin
		s2_value = s2_entry.a;
		case (s2_entry.op)
			fpq_pkg::OP_MIN: s2_value = s2_a_lt_b ? s2_entry.a : s2_entry.b;
			fpq_pkg::OP_MAX: s2_value = s2_a_lt_b ? s2_entry.b : s2_entry.a;
			fpq_pkg::OP_NEG: s2_value = {~s2_entry.a[31], s2_entry.a[30:0]};
			fpq_pkg::OP_ABS: s2_value = {1'b0, s2_entry.a[30:0]};
			default: s2_value = s2_entry.a;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			result <= '0;
		end else begin
			s1_valid <= pop;
			s2_valid <= s1_valid;
			result.valid <= s2_valid;
			result.tag <= s2_entry.tag;
			result.value <= s2_value;
		end
	end

	// operand and compare payload travels without reset
	always_ff @(posedge clk) begin
		if (pop) begin
			s1_entry <= buf_mem[rd_ptr];
		end
		s2_entry <= s1_entry;
		s2_a_lt_b <= s1_a_lt_b;
	end

endmodule

/* rtl/fpq_pkg.sv */
/*
 * fp issue stage shared definitions
 * operation codes, the dispatch entry, the issue packet, the lane result,
 * the configuration word and the register map used by the issue queue,
 * the selector, the lanes and the configuration block
 */
package fpq_pkg;

	// ========================================
	// basic widths and codes
	// ========================================

	// tag width, shared by the result tag and the wakeup source tag
	parameter int TAG_W = 6;

	// sign and compare operations executed by the lanes
	typedef enum logic [1:0] {
		OP_MIN = 2'd0,
		OP_MAX = 2'd1,
		OP_NEG = 2'd2,
		OP_ABS = 2'd3
	} fp_op_e;

	// ========================================
	// payload structs
	// ========================================

	// one queue entry as written by dispatch
	// src_ready is set at dispatch or later by a matching wakeup
	typedef struct packed {
		fp_op_e           op;
		logic [TAG_W-1:0] tag;
		logic [TAG_W-1:0] src_tag;
		logic             src_ready;
		logic             sync;
		logic [31:0]      a;
		logic [31:0]      b;
	} fp_entry_t;

	// registered packet from the selector to a lane
	typedef struct packed {
		logic      valid;
		fp_entry_t entry;
	} fp_issue_t;

	// lane output, valid for a single cycle
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [31:0]      value;
	} fp_result_t;

	// steering word from the register block to the selector
	typedef struct packed {
		logic [1:0] lane_en;
		logic       issue_hold;
	} fp_cfg_t;

	// ========================================
	// register map
	// ========================================

	// control register, bits 1:0 lane enables and bit 2 issue hold
	parameter logic [1:0] CFG_ADDR_CTRL = 2'd0;
	// both lanes come out of reset enabled
	parameter logic [1:0] CFG_LANE_EN_RST = 2'b11;

endpackage

/* tb.f */
+incdir+dv
rtl/fpq_pkg.sv
rtl/fp_issue_queue.sv
rtl/fp_issue_select.sv
rtl/fp_issue_cfg.sv
rtl/fp_lane.sv
rtl/fp_issue_top.sv
dv/fp_issue_tb.sv
